/* src/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`default_nettype none

`define RV_XLEN  32   // Instruction and immediate width
`define RV_REG_W 5    // Register index width
`define RV_OP_W  6    // Operation code, 46 values

`default_nettype wire

`endif

/* src/rv_isa_pkg.sv */
`include "rv_defs.svh"
`default_nettype none

package rv_isa_pkg;

  // Major opcodes, bits 6:0 of the word
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,   // R-type and M extension
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } major_opcode_e;

  // Decoded operation, sequential from 0
  typedef enum logic [`RV_OP_W-1:0] {
    OP_ADD,      // 0
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_MUL,      // 10, M extension
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU,
    OP_ADDI,     // 18
    OP_SLTI,
    OP_SLTIU,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_LB,       // 27
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,       // 32
    OP_SH,
    OP_SW,
    OP_BEQ,      // 35
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_JAL,      // 41
    OP_JALR,
    OP_LUI,
    OP_AUIPC,    // 44
    OP_ILLEGAL   // 45, also CSR, FENCE, ECALL
  } rv_op_e;

  // Immediate layout per instruction format
  typedef enum logic [2:0] {
    FMT_R = 3'd0,   // No immediate
    FMT_I = 3'd1,
    FMT_S = 3'd2,
    FMT_B = 3'd3,
    FMT_U = 3'd4,
    FMT_J = 3'd5
  } imm_fmt_e;

endpackage

`default_nettype wire

/* src/rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

  // Two-phase sequencing of the decode front end
  typedef enum logic {
    FETCH   = 1'b0,   // Ready for a new word
    EXECUTE = 1'b1    // Word held in IR
  } phase_e;

endpackage

`default_nettype wire

/* src/decode_if.sv */
`include "rv_defs.svh"
`default_nettype none

// IR to operand stage bundle
interface decode_if import rv_isa_pkg::*; ();

  logic                valid;   // One-cycle strobe per accepted word
  logic [`RV_XLEN-1:0] word;    // Latched instruction
  rv_op_e              op;      // Classified operation
  imm_fmt_e            fmt;     // Immediate layout

  modport producer (
    output valid,
    output word,
    output op,
    output fmt
  );

  modport consumer (
    input valid,
    input word,
    input op,
    input fmt
  );

endinterface

`default_nettype wire

/* src/phase_ctrl.sv */
`default_nettype none

module phase_ctrl import rv_ctrl_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,   // Upstream strobe
  output phase_e phase,
  output logic   accept,     // Word taken at this edge
  output logic   ready       // High only in FETCH
);

  phase_e phase_next;

  assign ready  = (phase == FETCH);
  assign accept = in_valid && ready;   // Strobes in EXECUTE are dropped

  always_comb begin
    phase_next = phase;
    case (phase)
      FETCH: begin
        if (accept) begin
          phase_next = EXECUTE;
        end
      end
      EXECUTE: phase_next = FETCH;     // Always exactly one cycle
      default: phase_next = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= FETCH;
    end else begin
      phase <= phase_next;
    end
  end

  // EXECUTE never held for two cycles in a row
  assert property (@(posedge clk) disable iff (!rst_n)
    (phase == EXECUTE) |=> (phase == FETCH))
    else $error("phase_ctrl: EXECUTE lasted more than one cycle");

endmodule

`default_nettype wire

/* src/instruction_register.sv */
`include "rv_defs.svh"
`default_nettype none

module instruction_register import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                accept,    // From phase_ctrl
  input  phase_e              phase,
  input  logic [`RV_XLEN-1:0] in_word,
  decode_if.producer          dec
);

  major_opcode_e opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          load;       // IR write enable
  rv_op_e        op_next;
  imm_fmt_e      fmt_next;

  assign opcode = major_opcode_e'(in_word[6:0]);
  assign funct3 = in_word[14:12];
  assign funct7 = in_word[31:25];
  assign load   = accept && (phase == FETCH);   // Words only enter in FETCH

  // Classify the incoming word, fmt follows the major opcode alone
  always_comb begin
    op_next  = OP_ILLEGAL;
    fmt_next = FMT_R;            // Unknown opcodes carry no immediate
    case (opcode)
      OPC_OP: begin
        casez ({funct7, funct3})
          10'b0000000_000: op_next = OP_ADD;
          10'b0100000_000: op_next = OP_SUB;
          10'b0000000_001: op_next = OP_SLL;
          10'b0000000_010: op_next = OP_SLT;
          10'b0000000_011: op_next = OP_SLTU;
          10'b0000000_100: op_next = OP_XOR;
          10'b0000000_101: op_next = OP_SRL;
          10'b0100000_101: op_next = OP_SRA;
          10'b0000000_110: op_next = OP_OR;
          10'b0000000_111: op_next = OP_AND;
          10'b0000001_000: op_next = OP_MUL;      // M extension
          10'b0000001_001: op_next = OP_MULH;
          10'b0000001_010: op_next = OP_MULHSU;
          10'b0000001_011: op_next = OP_MULHU;
          10'b0000001_100: op_next = OP_DIV;
          10'b0000001_101: op_next = OP_DIVU;
          10'b0000001_110: op_next = OP_REM;
          10'b0000001_111: op_next = OP_REMU;
          default:         op_next = OP_ILLEGAL;  // Bad funct7
        endcase
      end
      OPC_OP_IMM: begin
        fmt_next = FMT_I;
        casez ({funct7, funct3})
          10'b???????_000: op_next = OP_ADDI;
          10'b???????_010: op_next = OP_SLTI;
          10'b???????_011: op_next = OP_SLTIU;
          10'b???????_100: op_next = OP_XORI;
          10'b???????_110: op_next = OP_ORI;
          10'b???????_111: op_next = OP_ANDI;
          10'b0000000_001: op_next = OP_SLLI;     // Shifts need clean funct7
          10'b0000000_101: op_next = OP_SRLI;
          10'b0100000_101: op_next = OP_SRAI;
          default:         op_next = OP_ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        fmt_next = FMT_I;
        case (funct3)
          3'b000:  op_next = OP_LB;
          3'b001:  op_next = OP_LH;
          3'b010:  op_next = OP_LW;
          3'b100:  op_next = OP_LBU;
          3'b101:  op_next = OP_LHU;
          default: op_next = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        fmt_next = FMT_S;
        case (funct3)
          3'b000:  op_next = OP_SB;
          3'b001:  op_next = OP_SH;
          3'b010:  op_next = OP_SW;
          default: op_next = OP_ILLEGAL;
        endcase
      end
      OPC_BRANCH: begin
        fmt_next = FMT_B;
        case (funct3)
          3'b000:  op_next = OP_BEQ;
          3'b001:  op_next = OP_BNE;
          3'b100:  op_next = OP_BLT;
          3'b101:  op_next = OP_BGE;
          3'b110:  op_next = OP_BLTU;
          3'b111:  op_next = OP_BGEU;
          default: op_next = OP_ILLEGAL;
        endcase
      end
      OPC_JAL: begin
        fmt_next = FMT_J;
        op_next  = OP_JAL;
      end
      OPC_JALR: begin
        fmt_next = FMT_I;
        if (funct3 == 3'b000) begin
          op_next = OP_JALR;
        end
      end
      OPC_LUI: begin
        fmt_next = FMT_U;
        op_next  = OP_LUI;
      end
      OPC_AUIPC: begin
        fmt_next = FMT_U;
        op_next  = OP_AUIPC;
      end
      default: op_next = OP_ILLEGAL;   // SYSTEM, MISC-MEM and the rest
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec.valid <= 1'b0;
      dec.word  <= '0;
      dec.op    <= OP_ILLEGAL;
      dec.fmt   <= FMT_R;
    end else begin
      dec.valid <= load;          // Pulse in the EXECUTE cycle
      if (load) begin
        dec.word <= in_word;
        dec.op   <= op_next;
        dec.fmt  <= fmt_next;
      end
    end
  end

  // IR content moves only on the edge that accepted a word
  assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(dec.word) |-> $past(accept))
    else $error("instruction_register: word changed without accept");

  // Decoded strobe lines up with the sequencer phase
  assert property (@(posedge clk) disable iff (!rst_n)
    dec.valid |-> (phase == EXECUTE))
    else $error("instruction_register: valid outside EXECUTE");

endmodule

`default_nettype wire

/* src/operand_extract.sv */
`include "rv_defs.svh"
`default_nettype none

module operand_extract import rv_isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  decode_if.consumer           dec,
  output logic                 out_valid,   // One-cycle result strobe
  output rv_op_e               out_op,
  output logic [`RV_REG_W-1:0] out_rd,
  output logic [`RV_REG_W-1:0] out_rs1,
  output logic [`RV_REG_W-1:0] out_rs2,
  output logic [`RV_XLEN-1:0]  out_imm
);

  logic [`RV_XLEN-1:0] w;
  logic [`RV_XLEN-1:0] imm;    // Assembled immediate

  assign w = dec.word;

  // Immediate per format, sign taken from bit 31
  always_comb begin
    case (dec.fmt)
      FMT_I:   imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
      FMT_S:   imm = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
      FMT_B: begin
        // Branch offset bits are scattered, LSB always zero
        imm = {{(`RV_XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      FMT_U:   imm = {w[31:12], 12'b0};   // Upper 20 bits
      FMT_J: begin
        imm = {{(`RV_XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: imm = '0;                  // R-type and unknown
    endcase
  end

  // Strobe with reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= dec.valid;
    end
  end

  // Payload, loaded only on a decoded word
  always_ff @(posedge clk) begin
    if (dec.valid) begin
      out_op  <= dec.op;
      out_rd  <= w[11:7];     // Fixed field positions
      out_rs1 <= w[19:15];
      out_rs2 <= w[24:20];
      out_imm <= imm;
    end
  end

  // Every result traces back to an IR strobe
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(dec.valid))
    else $error("operand_extract: out_valid without dec.valid");

endmodule

`default_nettype wire

/* src/rv_decode_top.sv */
`include "rv_defs.svh"
`default_nettype none

module rv_decode_top import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  logic [`RV_XLEN-1:0]  in_word,
  output logic                 ready,
  output logic                 out_valid,
  output rv_op_e               out_op,
  output logic [`RV_REG_W-1:0] out_rd,
  output logic [`RV_REG_W-1:0] out_rs1,
  output logic [`RV_REG_W-1:0] out_rs2,
  output logic [`RV_XLEN-1:0]  out_imm
);

  phase_e phase;
  logic   accept;

  decode_if dec_bus ();   // IR to operand stage

  phase_ctrl u_phase_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .phase    (phase),
    .accept   (accept),
    .ready    (ready)
  );

  instruction_register u_ir (
    .clk     (clk),
    .rst_n   (rst_n),
    .accept  (accept),
    .phase   (phase),
    .in_word (in_word),
    .dec     (dec_bus.producer)
  );

  operand_extract u_operand (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec_bus.consumer),
    .out_valid (out_valid),
    .out_op    (out_op),
    .out_rd    (out_rd),
    .out_rs1   (out_rs1),
    .out_rs2   (out_rs2),
    .out_imm   (out_imm)
  );

endmodule

`default_nettype wire

/* tb/tb_rv_decode.sv */
`include "rv_defs.svh"
`default_nettype none

module tb_rv_decode import rv_isa_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_WORDS   = 24 + 128 + 3 + 5 + 1 + 200;   // Directed, busy, random
  localparam int STIM_CYCLES = 5 + 2 * NUM_WORDS + 10;       // Reset, two per word, drain
  localparam int TIMEOUT     = 2 * STIM_CYCLES + 50;

  typedef struct packed {
    logic [`RV_OP_W-1:0]  op;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_XLEN-1:0]  imm;
  } expect_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 in_valid;
  logic [`RV_XLEN-1:0]  in_word;
  logic                 ready;
  logic                 out_valid;
  rv_op_e               out_op;
  logic [`RV_REG_W-1:0] out_rd;
  logic [`RV_REG_W-1:0] out_rs1;
  logic [`RV_REG_W-1:0] out_rs2;
  logic [`RV_XLEN-1:0]  out_imm;
  logic                 acc;             // Word taken at this rising edge

  expect_t exp_q [$];                    // One entry per accepted word
  expect_t head;                         // Entry for the result now on the outputs
  int      rd_idx     = 0;
  int      n_sent     = 0;
  int      n_results  = 0;
  int      cycle_cnt  = 0;
  integer  seed;

  always #50 clk = ~clk;                 // 100 ns period

  rv_decode_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .ready     (ready),
    .out_valid (out_valid),
    .out_op    (out_op),
    .out_rd    (out_rd),
    .out_rs1   (out_rs1),
    .out_rs2   (out_rs2),
    .out_imm   (out_imm)
  );

  assign acc = in_valid && ready;

  // Reset state checks skip the first edge before the phase register loads
  assert property (@(posedge clk) (!rst_n && cycle_cnt > 0) |-> (ready && !out_valid))
    else fail_run("ready low or out_valid high while in reset");
  assert property (@(posedge clk) $rose(rst_n) |-> (ready && !out_valid))
    else fail_run("ready low or out_valid high right after reset");
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(acc, 2))
    else fail_run("out_valid not exactly two cycles after an accepted word");
  assert property (@(posedge clk) disable iff (!rst_n) acc |=> !ready)
    else fail_run("ready still high in the cycle after acceptance");

  // Result fields against the queue head
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (out_op == head.op))
    else fail_run($sformatf("FAILED out_op: got %h expected %h", out_op, head.op));
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (out_rd == head.rd))
    else fail_run($sformatf("FAILED out_rd: got %h expected %h", out_rd, head.rd));
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (out_rs1 == head.rs1))
    else fail_run($sformatf("FAILED out_rs1: got %h expected %h", out_rs1, head.rs1));
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (out_rs2 == head.rs2))
    else fail_run($sformatf("FAILED out_rs2: got %h expected %h", out_rs2, head.rs2));
  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (out_imm == head.imm))
    else fail_run($sformatf("FAILED out_imm: got %h expected %h", out_imm, head.imm));

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // Expected decode straight from the RV32IM encoding rules
  function automatic expect_t ref_decode(input logic [`RV_XLEN-1:0] w);
    expect_t     e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [12:0] b_off;
    logic [20:0] j_off;
    f3    = w[14:12];
    f7    = w[31:25];
    b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    e.op  = OP_ILLEGAL;
    e.rd  = w[11:7];
    e.rs1 = w[19:15];
    e.rs2 = w[24:20];
    e.imm = '0;                           // R-type and unknown opcodes
    case (w[6:0])
      OPC_OP: begin
        if (f7 == 7'h01) e.op = OP_MUL + {3'b000, f3};   // M ops in funct3 order
        else if (f7 == 7'h20 && f3 == 3'd0) e.op = OP_SUB;
        else if (f7 == 7'h20 && f3 == 3'd5) e.op = OP_SRA;
        else if (f7 == 7'h00) begin
          case (f3)
            3'd0: e.op = OP_ADD;
            3'd1: e.op = OP_SLL;
            3'd2: e.op = OP_SLT;
            3'd3: e.op = OP_SLTU;
            3'd4: e.op = OP_XOR;
            3'd5: e.op = OP_SRL;
            3'd6: e.op = OP_OR;
            default: e.op = OP_AND;
          endcase
        end
      end
      OPC_OP_IMM: begin
        e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
        case (f3)
          3'd0: e.op = OP_ADDI;
          3'd2: e.op = OP_SLTI;
          3'd3: e.op = OP_SLTIU;
          3'd4: e.op = OP_XORI;
          3'd6: e.op = OP_ORI;
          3'd7: e.op = OP_ANDI;
          3'd1: if (f7 == 7'h00) e.op = OP_SLLI;
          default: begin
            if (f7 == 7'h00) e.op = OP_SRLI;
            else if (f7 == 7'h20) e.op = OP_SRAI;
          end
        endcase
      end
      OPC_LOAD: begin
        e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
        case (f3)
          3'd0: e.op = OP_LB;
          3'd1: e.op = OP_LH;
          3'd2: e.op = OP_LW;
          3'd4: e.op = OP_LBU;
          3'd5: e.op = OP_LHU;
          default: e.op = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
        if (f3 < 3'd3) e.op = OP_SB + {3'b000, f3};
      end
      OPC_BRANCH: begin
        e.imm = {{(`RV_XLEN-13){b_off[12]}}, b_off};
        if (f3[2]) e.op = OP_BLT + {4'b0000, f3[1:0]};   // BLT..BGEU
        else if (!f3[1]) e.op = OP_BEQ + {5'b00000, f3[0]};
      end
      OPC_JAL: begin
        e.imm = {{(`RV_XLEN-21){j_off[20]}}, j_off};
        e.op  = OP_JAL;
      end
      OPC_JALR: begin
        e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
        if (f3 == 3'd0) e.op = OP_JALR;
      end
      OPC_LUI: begin
        e.imm = {w[31:12], 12'h000};
        e.op  = OP_LUI;
      end
      OPC_AUIPC: begin
        e.imm = {w[31:12], 12'h000};
        e.op  = OP_AUIPC;
      end
      default: e.op = OP_ILLEGAL;
    endcase
    return e;
  endfunction

  // Mostly legal encodings with a fifth raw random words
  task automatic make_random_word(output logic [`RV_XLEN-1:0] w);
    int kind;
    w    = $random(seed);
    kind = $unsigned($random(seed)) % 10;
    case (kind)
      2: begin
        w[6:0] = OPC_OP;
        case ($unsigned($random(seed)) % 3)
          0: w[31:25] = 7'h00;
          1: w[31:25] = 7'h20;
          default: w[31:25] = 7'h01;
        endcase
      end
      3: begin
        w[6:0] = OPC_OP_IMM;
        if (w[13:12] == 2'b01) w[31:25] = w[30] ? 7'h20 : 7'h00;   // Shift forms
      end
      4: w[6:0] = OPC_LOAD;
      5: w[6:0] = OPC_STORE;
      6: w[6:0] = OPC_BRANCH;
      7: w[6:0] = OPC_JAL;
      8: begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
      end
      9: w[6:0] = w[7] ? OPC_LUI : OPC_AUIPC;
      default: ;                           // Raw word
    endcase
  endtask

  // Offers the word at the next FETCH from a falling edge
  task automatic send_word(input logic [`RV_XLEN-1:0] w);
    while (!ready) @(negedge clk);
    in_valid = 1'b1;
    in_word  = w;
    n_sent++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_while_busy(input logic [`RV_XLEN-1:0] kept,
                                 input logic [`RV_XLEN-1:0] dropped);
    while (!ready) @(negedge clk);
    in_valid = 1'b1;
    in_word  = kept;
    n_sent++;
    @(negedge clk);
    in_word = dropped;                    // Valid held high during EXECUTE
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst_n && acc) begin
      exp_q.push_back(ref_decode(in_word));
    end
  end

  // Head moves mid-cycle so the field assertions see it at the next edge
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      n_results++;
      if (rd_idx >= exp_q.size()) fail_run("out_valid with no accepted word pending");
      else begin
        head   = exp_q[rd_idx];
        rd_idx = rd_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) fail_run($sformatf("timeout after %0d cycles", cycle_cnt));
  end

  initial begin : stimulus
    logic [`RV_XLEN-1:0] w;
    logic [6:0]          f7_sel;
    logic [6:0]          fmt_opc [8];
    int                  f3;
    int                  m;
    int                  s;
    int                  k;
    seed     = 79402;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_word  = '0;
    fmt_opc  = '{OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                 OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    for (m = 0; m < 3; m++) begin          // Base, alternate and M funct7
      f7_sel = (m == 0) ? 7'h00 : (m == 1) ? 7'h20 : 7'h01;
      for (f3 = 0; f3 < 8; f3++) begin
        w = {f7_sel, 5'(f3 * 3 + 1), 5'(f3 + m * 8), 3'(f3), 5'(31 - f3), OPC_OP};
        send_word(w);
      end
    end

    for (m = 0; m < 8; m++) begin          // Every immediate format with both signs
      for (f3 = 0; f3 < 8; f3++) begin
        for (s = 0; s < 2; s++) begin
          w = {1'(s), 16'(f3 * 16'h2b37 + m * 16'h0911), 3'(f3), 5'(m * 4 + 3), fmt_opc[m]};
          send_word(w);
        end
      end
    end
    send_word(32'h00311093);               // slli x1, x2, 3
    send_word(32'h00315093);               // srli
    send_word(32'h40315093);               // srai

    send_word(32'h20000033);               // OP with bad funct7
    send_word(32'h000020e7);               // JALR funct3 010
    send_word(32'h0000007f);               // Unknown major opcode
    send_word(32'h00000073);               // ECALL
    send_word(32'h0000000f);               // FENCE

    send_while_busy(32'h00a00093, 32'h40b50533);

    for (k = 0; k < 200; k++) begin
      make_random_word(w);
      send_word(w);
    end

    while (n_results < n_sent) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/decode_if.sv
src/phase_ctrl.sv
src/instruction_register.sv
src/operand_extract.sv
src/rv_decode_top.sv
tb/tb_rv_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_rv_decode -o sim_tb_rv_decode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_rv_decode 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
